//--- tb.f
source/dhcp_tx_pkg.sv
source/dhcp_opt_loader.sv
source/dhcp_opt_slot.sv
source/dhcp_opt_packer.sv
source/dhcp_tx_serializer.sv
source/dhcp_tx_top.sv
tests/dhcp_tx_checker.sv
tests/dhcp_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module dhcp_tx_tb -f tb.f -o dhcp_tx_sim

out=$(./obj_dir/dhcp_tx_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

//--- tests/dhcp_tx_tb.sv
`timescale 1ns/1ps

module dhcp_tx_tb;
  import dhcp_tx_pkg::*;

  localparam int                  HN_LEN      = 8;
  localparam int                  DN_LEN      = 7;
  localparam int                  FQ_LEN      = 11;
  localparam logic [8*HN_LEN-1:0] HOSTNAME    = "localnya";
  localparam logic [8*DN_LEN-1:0] DOMAIN_NAME = "nya.com";
  localparam logic [8*FQ_LEN-1:0] FQDN        = "www.nya.com";
  localparam int                  N_RAND      = 12;
  localparam int                  N_PKT       = N_RAND + 4;  // Plus none, all, busy, reuse
  localparam int                  RDY_CYC     = 10;          // Strobe to first rdy sample
  localparam int                  PKT_CYC     = (DHCP_HDR_LEN + OPT_TOT_LEN_TX) * 4;
  localparam int                  SEED        = 32'h7860_3175;

  logic       clk;
  logic       fsm_rst;
  logic       req_val;
  dhcp_req_t  req;
  logic       udp_req;
  logic       udp_rdy;
  udp_meta_t  udp_meta;
  udp_strm_t  udp_strm;
  logic       done;
  logic [7:0] exp_q[$];   // Expected packet bytes
  logic [7:0] body_q[$];  // Option body being built
  udp_meta_t  exp_meta;
  int         errors;
  int         checks;
  int         tests;

  dhcp_tx_top #(
    .HOSTNAME_LEN    (8'(HN_LEN)),
    .DOMAIN_NAME_LEN (8'(DN_LEN)),
    .FQDN_LEN        (8'(FQ_LEN)),
    .HOSTNAME        (HOSTNAME),
    .DOMAIN_NAME     (DOMAIN_NAME),
    .FQDN            (FQDN)
  ) dut (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .req_val  (req_val),
    .req      (req),
    .udp_req  (udp_req),
    .udp_rdy  (udp_rdy),
    .udp_meta (udp_meta),
    .udp_strm (udp_strm),
    .done     (done)
  );

  always #10 clk = ~clk;

  initial begin
    #((N_PKT * PKT_CYC + 500) * 20);
    $display("watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_meta(input udp_meta_t got, input udp_meta_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: meta %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_beat(input udp_strm_t got, input udp_strm_t exp, input string what);
    checks++;
    if (got.val !== exp.val || got.sof !== exp.sof || got.eof !== exp.eof ||
        (exp.val && got.dat !== exp.dat)) begin
      errors++;
      $display("FAILED %0t: beat %s got dat %h val/sof/eof %b%b%b", $time, what,
               got.dat, got.val, got.sof, got.eof);
      $display("  expected dat %h val/sof/eof %b%b%b", exp.dat, exp.val, exp.sof, exp.eof);
    end
  endtask

  task automatic check_done(input logic got_done, input logic got_rdy,
                            input logic exp_done, input logic exp_rdy, input string what);
    checks++;
    if (got_done !== exp_done || got_rdy !== exp_rdy) begin
      errors++;
      $display("FAILED %0t: %s done %b rdy %b, expected done %b rdy %b", $time, what,
               got_done, got_rdy, exp_done, exp_rdy);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  task automatic add_bytes(input logic [127:0] v, input int n);
    for (int j = n - 1; j >= 0; j--) begin
      body_q.push_back(v[8*j +: 8]);  // Most significant byte first
    end
  endtask

  // Code, length, body, then PAD up to a full slot
  task automatic add_option(input logic [7:0] code);
    int len;
    len = (body_q.size() > OPT_LEN - 2) ? OPT_LEN - 2 : body_q.size();
    exp_q.push_back(code);
    exp_q.push_back(8'(len));
    for (int k = 0; k < OPT_LEN - 2; k++) begin
      exp_q.push_back((k < len) ? body_q[k] : DHCP_OPT_PAD);
    end
    body_q.delete();
  endtask

  task automatic build_packet(input dhcp_req_t r);
    body_q.delete();
    add_bytes(r.hdr.op, 1);
    add_bytes(r.hdr.htype, 1);
    add_bytes(r.hdr.hlen, 1);
    add_bytes(r.hdr.hops, 1);
    add_bytes(r.hdr.xid, 4);
    add_bytes(r.hdr.secs, 2);
    add_bytes(r.hdr.flags, 2);
    add_bytes(r.hdr.ciaddr, 4);
    add_bytes(r.hdr.yiaddr, 4);
    add_bytes(r.hdr.siaddr, 4);
    add_bytes(r.hdr.giaddr, 4);
    add_bytes(r.hdr.chaddr, 16);
    add_bytes(r.hdr.cookie, 4);
    exp_q = body_q;
    body_q.delete();
    if (r.opt_pres[0]) begin
      add_bytes(r.msg_type, 1);
      add_option(DHCP_OPT_MSG_TYPE);
    end
    if (r.opt_pres[1]) begin
      add_bytes(r.req_ip, 4);
      add_option(DHCP_OPT_REQ_IP);
    end
    if (r.opt_pres[2]) begin
      add_bytes(8'd1, 1);           // Ethernet hardware type
      add_bytes(r.cli_id_mac, 6);
      add_option(DHCP_OPT_CLI_ID);
    end
    if (r.opt_pres[3]) begin
      add_bytes(HOSTNAME, HN_LEN);
      add_option(DHCP_OPT_HOSTNAME);
    end
    if (r.opt_pres[4]) begin
      add_bytes(DOMAIN_NAME, DN_LEN);
      add_option(DHCP_OPT_DOMAIN_NAME);
    end
    if (r.opt_pres[5]) begin
      add_bytes({r.fqdn_flags, r.rcode1, r.rcode2}, 3);
      add_bytes(FQDN, FQ_LEN);
      add_option(DHCP_OPT_FQDN);
    end
    exp_q.push_back(DHCP_OPT_END);
    exp_meta.src_port = DHCP_CLI_PORT;
    exp_meta.dst_port = DHCP_SRV_PORT;
    exp_meta.length   = 16'(UDP_HDR_LEN + exp_q.size());
    exp_meta.cks      = 16'd0;
    exp_meta.src_ip   = r.src_ip;
    exp_meta.dst_ip   = r.dst_ip;
    exp_meta.ipv4_id  = r.ipv4_id;
    exp_meta.dst_mac  = MAC_BROADCAST;
  endtask

  function automatic dhcp_req_t rand_req(input logic [OPT_NUM_TX-1:0] pres);
    logic [32*19-1:0] raw;
    dhcp_req_t        r;
    for (int i = 0; i < 19; i++) begin
      raw[32*i +: 32] = $urandom;
    end
    r          = dhcp_req_t'(raw[$bits(dhcp_req_t)-1:0]);
    r.opt_pres = pres;
    r.hdr.op   = 8'd1;  // BOOTREQUEST
    return r;
  endfunction

  ////////////////////////////////////////
  // Packet driver and monitor
  ////////////////////////////////////////
  // Sample on each falling edge, then drive the next inputs
  task automatic run_packet(input dhcp_req_t r, input int gap_pct, input int busy_at);
    udp_strm_t exp_beat;
    int        idx;
    int        cycles;
    int        eof_cyc;
    bit        eof_seen;
    bit        prev_req;
    bit        prev_rdy;
    bit        exp_done;
    bit        exp_rdy;
    build_packet(r);
    idx      = 0;
    cycles   = 0;
    eof_cyc  = 0;
    eof_seen = 1'b0;
    prev_req = udp_req;
    prev_rdy = udp_rdy;
    req      = r;
    req_val  = 1'b1;
    while (!(eof_seen && cycles == eof_cyc + 2)) begin
      @(negedge clk);
      cycles++;
      exp_beat = '0;
      if (prev_req && prev_rdy && idx < exp_q.size()) begin
        exp_beat.val = 1'b1;
        exp_beat.dat = exp_q[idx];
        exp_beat.sof = (idx == 0);
        exp_beat.eof = (idx == exp_q.size() - 1);
      end
      check_beat(udp_strm, exp_beat, $sformatf("byte %0d", idx));
      if (exp_beat.val) idx++;
      if (exp_beat.eof) begin
        eof_seen = 1'b1;
        eof_cyc  = cycles;
      end
      exp_rdy  = (cycles >= RDY_CYC) && !(eof_seen && cycles > eof_cyc);
      exp_done = eof_seen && (cycles == eof_cyc + 1);
      check_done(done, udp_rdy, exp_done, exp_rdy, $sformatf("cycle %0d", cycles));
      if (cycles == RDY_CYC || (eof_seen && cycles == eof_cyc)) begin
        check_meta(udp_meta, exp_meta, $sformatf("cycle %0d", cycles));
      end
      prev_rdy = udp_rdy;
      udp_req  = ($urandom_range(99) >= gap_pct);
      prev_req = udp_req;
      if (busy_at > 0 && cycles % busy_at == 0 && !eof_seen) begin
        req     = rand_req(6'($urandom));  // Must be dropped by the DUT
        req_val = 1'b1;
      end else begin
        req_val = 1'b0;
      end
      if (cycles > PKT_CYC) begin
        errors++;
        $display("packet not finished, no done after %0d cycles", cycles);
        break;
      end
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %-12s %s (%0d errors)", name,
             (errors == err_before) ? "ok" : "mismatch", errors - err_before);
  endtask

  initial begin
    int err0;
    void'($urandom(SEED));
    clk     = 1'b0;
    fsm_rst = 1'b1;
    req_val = 1'b0;
    req     = '0;
    udp_req = 1'b0;
    errors  = 0;
    checks  = 0;
    tests   = 0;

    err0 = errors;
    repeat (4) @(negedge clk);
    check_beat(udp_strm, '0, "after reset");
    check_done(done, udp_rdy, 1'b0, 1'b0, "after reset");
    fsm_rst = 1'b0;
    end_test("reset", err0);

    err0 = errors;
    run_packet(rand_req('0), 0, 0);  // Header plus END only
    end_test("mask none", err0);
    err0 = errors;
    run_packet(rand_req('1), 0, 0);
    end_test("mask all", err0);

    // Random masks with gaps in udp_req
    for (int n = 0; n < N_RAND; n++) begin
      err0 = errors;
      run_packet(rand_req(6'($urandom)), $urandom_range(60), 0);
      end_test($sformatf("random %0d", n), err0);
    end

    err0 = errors;
    run_packet(rand_req(6'($urandom)), 30, 7);
    end_test("busy", err0);
    err0 = errors;
    run_packet(rand_req(6'($urandom)), 30, 0);  // Starts right after done
    end_test("reuse", err0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tests/dhcp_tx_checker.sv
`timescale 1ns/1ps

module dhcp_tx_checker (
  input  logic                                clk,
  input  logic                                fsm_rst,
  input  logic                                udp_req,
  input  logic                                udp_rdy,
  input  dhcp_tx_pkg::udp_strm_t              udp_strm,
  input  logic                                done,
  input  logic                                busy,
  input  logic                                load,
  input  logic [dhcp_tx_pkg::OPT_NUM_TX-1:0]  slot_val,
  input  logic                                opt_rdy
);

  ////////////////////////////////////////
  // UDP side handshake
  ////////////////////////////////////////
  // A beat answers a request seen while ready
  a_val_after_req: assert property (@(posedge clk) disable iff (fsm_rst)
    udp_strm.val |-> $past(udp_req && udp_rdy))
    else $error("stream beat without a request while ready");

  a_marks_need_val: assert property (@(posedge clk)
    (udp_strm.sof || udp_strm.eof) |-> udp_strm.val)
    else $error("sof or eof without val");

  a_rdy_after_done: assert property (@(posedge clk) disable iff (fsm_rst)
    done |=> !udp_rdy)
    else $error("rdy still high after done");

  // Outputs and pipeline strobes idle out of reset
  a_quiet_after_rst: assert property (@(posedge clk)
    fsm_rst |=> !(udp_rdy || udp_strm.val || udp_strm.sof || udp_strm.eof || done ||
                  busy || load || (|slot_val) || opt_rdy))
    else $error("signal active right after reset");

endmodule

bind dhcp_tx_top dhcp_tx_checker u_checker (
  .clk      (clk),
  .fsm_rst  (fsm_rst),
  .udp_req  (udp_req),
  .udp_rdy  (udp_rdy),
  .udp_strm (udp_strm),
  .done     (done),
  .busy     (busy),
  .load     (load),
  .slot_val (slot_val),
  .opt_rdy  (opt_rdy)
);

//--- source/dhcp_tx_top.sv
`timescale 1ns/1ps

module dhcp_tx_top #(
  parameter [7:0]                      HOSTNAME_LEN    = 8,
  parameter [7:0]                      DOMAIN_NAME_LEN = 7,
  parameter [7:0]                      FQDN_LEN        = 11,
  parameter [HOSTNAME_LEN-1:0][7:0]    HOSTNAME        = "localnya",
  parameter [DOMAIN_NAME_LEN-1:0][7:0] DOMAIN_NAME     = "nya.com",
  parameter [FQDN_LEN-1:0][7:0]        FQDN            = "www.nya.com"
) (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   req_val,
  input  dhcp_tx_pkg::dhcp_req_t req,
  input  logic                   udp_req,
  output logic                   udp_rdy,
  output dhcp_tx_pkg::udp_meta_t udp_meta,
  output dhcp_tx_pkg::udp_strm_t udp_strm,
  output logic                   done
);
  import dhcp_tx_pkg::*;

  opt_slot_in_t [OPT_NUM_TX-1:0]  slot_in;
  opt_slot_t [OPT_NUM_TX-1:0]     slots;
  logic [OPT_NUM_TX-1:0]          opt_pres;
  logic [OPT_NUM_TX-1:0]          slot_val;
  logic                           load;
  logic                           busy;
  logic                           opt_rdy;
  logic [OPT_TOT_LEN_TX-1:0][7:0] opts;
  logic [7:0]                     opt_len;

  dhcp_opt_loader #(
    .HOSTNAME_LEN    (HOSTNAME_LEN),
    .DOMAIN_NAME_LEN (DOMAIN_NAME_LEN),
    .FQDN_LEN        (FQDN_LEN),
    .HOSTNAME        (HOSTNAME),
    .DOMAIN_NAME     (DOMAIN_NAME),
    .FQDN            (FQDN)
  ) u_loader (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .req_val  (req_val),
    .req      (req),
    .done     (done),
    .slot_in  (slot_in),
    .opt_pres (opt_pres),
    .load     (load),
    .busy     (busy)
  );

  // Row of option formatters
  for (genvar i = 0; i < OPT_NUM_TX; i++) begin : g_slot
    dhcp_opt_slot u_slot (
      .clk      (clk),
      .fsm_rst  (fsm_rst),
      .load     (load),
      .pres     (opt_pres[i]),
      .slot_in  (slot_in[i]),
      .slot     (slots[i]),
      .slot_val (slot_val[i])
    );
  end

  dhcp_opt_packer u_packer (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .slot_val (slot_val),
    .slots    (slots),
    .opts     (opts),
    .opt_len  (opt_len),
    .opt_rdy  (opt_rdy)
  );

  dhcp_tx_serializer u_serializer (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .load    (req_val),     // Header is only valid with the strobe
    .hdr     (req.hdr),
    .src_ip  (req.src_ip),
    .dst_ip  (req.dst_ip),
    .ipv4_id (req.ipv4_id),
    .opt_rdy (opt_rdy),
    .opts    (opts),
    .opt_len (opt_len),
    .req     (udp_req),
    .rdy     (udp_rdy),
    .meta    (udp_meta),
    .strm    (udp_strm),
    .done    (done)
  );

endmodule

//--- source/dhcp_tx_serializer.sv
`timescale 1ns/1ps

module dhcp_tx_serializer (
  input  logic                                        clk,
  input  logic                                        fsm_rst,
  input  logic                                        load,
  input  dhcp_tx_pkg::dhcp_hdr_t                      hdr,
  input  logic [31:0]                                 src_ip,
  input  logic [31:0]                                 dst_ip,
  input  logic [15:0]                                 ipv4_id,
  input  logic                                        opt_rdy,
  input  logic [dhcp_tx_pkg::OPT_TOT_LEN_TX-1:0][7:0] opts,
  input  logic [7:0]                                  opt_len,
  input  logic                                        req,
  output logic                                        rdy,
  output dhcp_tx_pkg::udp_meta_t                      meta,
  output dhcp_tx_pkg::udp_strm_t                      strm,
  output logic                                        done
);
  import dhcp_tx_pkg::*;

  localparam int PKT_LEN = DHCP_HDR_LEN + OPT_TOT_LEN_TX; // Largest packet

  logic                    rst_int;
  logic                    armed;     // Header for this packet is held
  logic                    hdr_load;
  logic                    send;
  logic [7:0]              byte_cnt;
  logic [7:0]              pkt_last;  // Index of the last byte
  logic [PKT_LEN-1:0][7:0] pkt;       // Next byte always on top

  assign rst_int  = fsm_rst || done;      // Clears itself after the packet
  assign hdr_load = load && !armed;
  assign send     = rdy && req && !strm.eof; // No beat once the last one is out

  ////////////////////////////////////////
  // Control and UDP side
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_int) begin
      armed    <= 1'b0;
      rdy      <= 1'b0;
      done     <= 1'b0;
      byte_cnt <= '0;
      strm     <= '0;
      meta     <= '0;
    end else begin
      strm.val <= send;
      strm.sof <= send && (byte_cnt == 8'd0);
      strm.eof <= send && (byte_cnt == pkt_last);

      if (hdr_load) begin
        armed        <= 1'b1;
        meta.src_ip  <= src_ip;
        meta.dst_ip  <= dst_ip;
        meta.ipv4_id <= ipv4_id;
      end

      if (opt_rdy) begin // Options ready, packet can go
        rdy           <= 1'b1;
        meta.src_port <= DHCP_CLI_PORT;
        meta.dst_port <= DHCP_SRV_PORT;
        meta.length   <= 16'(DHCP_HDR_LEN + UDP_HDR_LEN) + 16'(opt_len);
        meta.cks      <= 16'd0;           // Checksum not computed
        meta.dst_mac  <= MAC_BROADCAST;
      end

      if (send) begin
        strm.dat <= pkt[PKT_LEN-1];
        byte_cnt <= byte_cnt + 8'd1;
      end

      if (strm.eof) begin
        rdy  <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Packet buffer
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (hdr_load) begin
      pkt[PKT_LEN-1 -: DHCP_HDR_LEN] <= hdr;
    end
    if (opt_rdy) begin
      pkt[OPT_TOT_LEN_TX-1:0] <= opts;
      pkt_last                <= 8'(DHCP_HDR_LEN - 1) + opt_len;
    end
    if (send) begin
      pkt <= {pkt[PKT_LEN-2:0], DHCP_OPT_PAD}; // One byte out per request
    end
  end

endmodule

//--- source/dhcp_opt_packer.sv
`timescale 1ns/1ps

module dhcp_opt_packer (
  input  logic                                                      clk,
  input  logic                                                      fsm_rst,
  input  logic [dhcp_tx_pkg::OPT_NUM_TX-1:0]                        slot_val,
  input  dhcp_tx_pkg::opt_slot_t [dhcp_tx_pkg::OPT_NUM_TX-1:0]      slots,
  output logic [dhcp_tx_pkg::OPT_TOT_LEN_TX-1:0][7:0]               opts,
  output logic [7:0]                                                opt_len,
  output logic                                                      opt_rdy
);
  import dhcp_tx_pkg::*;

  opt_slot_t [OPT_NUM_TX-1:0]    proto;     // Slots waiting to be packed
  logic [$clog2(OPT_NUM_TX)-1:0] opt_cnt;
  logic                          shift_opt;
  logic                          start;
  logic                          last_step;
  logic [7:0]                    len_add;

  assign start     = &slot_val; // Every slot has its data
  assign last_step = shift_opt && (opt_cnt == OPT_NUM_TX - 1);

  // Kept slot adds a full record, last step adds END
  always_comb begin
    len_add = proto[OPT_NUM_TX-1].present ? 8'(OPT_LEN) : 8'd0;
    if (last_step) begin
      len_add = len_add + 8'd1;
    end
  end

  ////////////////////////////////////////
  // Shift control
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      shift_opt <= 1'b0;
      opt_cnt   <= '0;
      opt_len   <= '0;
      opt_rdy   <= 1'b0;
    end else begin
      opt_rdy <= 1'b0;
      if (start) begin
        shift_opt <= 1'b1;
        opt_cnt   <= '0;
        opt_len   <= '0;
      end else if (shift_opt) begin
        opt_cnt <= opt_cnt + 1'b1;
        opt_len <= opt_len + len_add;
        if (last_step) begin
          shift_opt <= 1'b0;
          opt_rdy   <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Option bytes
  ////////////////////////////////////////
  // Slots are taken from the last one down, each kept slot pushed in on top.
  // END is seeded on top at start and so ends up right below the kept slots
  always_ff @(posedge clk) begin
    if (start) begin
      proto <= slots;
      opts  <= {DHCP_OPT_END, {(OPT_TOT_LEN_TX-1){DHCP_OPT_PAD}}};
    end else if (shift_opt) begin
      proto[OPT_NUM_TX-1:1] <= proto[OPT_NUM_TX-2:0];
      if (proto[OPT_NUM_TX-1].present) begin
        opts <= {proto[OPT_NUM_TX-1].data, opts[OPT_TOT_LEN_TX-1:OPT_LEN]};
      end
    end
  end

endmodule

//--- source/dhcp_opt_slot.sv
`timescale 1ns/1ps

module dhcp_opt_slot (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      load,
  input  logic                      pres,
  input  dhcp_tx_pkg::opt_slot_in_t slot_in,
  output dhcp_tx_pkg::opt_slot_t    slot,
  output logic                      slot_val
);
  import dhcp_tx_pkg::*;

  localparam logic [7:0] LEN_MAX = 8'(OPT_LEN - 2); // Code and length take two bytes

  logic [7:0]              len_clamp;
  logic [OPT_LEN-1:0][7:0] data_nxt;

  assign len_clamp = (slot_in.len > LEN_MAX) ? LEN_MAX : slot_in.len;

  // Code, length, payload bytes, then PAD
  always_comb begin
    data_nxt[OPT_LEN-1] = slot_in.code;
    data_nxt[OPT_LEN-2] = len_clamp;
    for (int i = 0; i < OPT_LEN - 2; i++) begin
      data_nxt[OPT_LEN-3-i] = (i < int'(len_clamp)) ?
                              slot_in.payload.raw[OPT_LEN-3-i] : DHCP_OPT_PAD;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      slot_val <= 1'b0;
    end else begin
      slot_val <= load; // Pulse follows the load strobe
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      slot.present <= pres;
      slot.data    <= data_nxt;
    end
  end

endmodule

//--- source/dhcp_opt_loader.sv
`timescale 1ns/1ps

module dhcp_opt_loader #(
  parameter [7:0]                      HOSTNAME_LEN    = 8,
  parameter [7:0]                      DOMAIN_NAME_LEN = 7,
  parameter [7:0]                      FQDN_LEN        = 11,
  parameter [HOSTNAME_LEN-1:0][7:0]    HOSTNAME        = "localnya",
  parameter [DOMAIN_NAME_LEN-1:0][7:0] DOMAIN_NAME     = "nya.com",
  parameter [FQDN_LEN-1:0][7:0]        FQDN            = "www.nya.com"
) (
  input  logic                                                   clk,
  input  logic                                                   fsm_rst,
  input  logic                                                   req_val,
  input  dhcp_tx_pkg::dhcp_req_t                                 req,
  input  logic                                                   done,
  output dhcp_tx_pkg::opt_slot_in_t [dhcp_tx_pkg::OPT_NUM_TX-1:0] slot_in,
  output logic [dhcp_tx_pkg::OPT_NUM_TX-1:0]                     opt_pres,
  output logic                                                   load,
  output logic                                                   busy
);
  import dhcp_tx_pkg::*;

  localparam int PL_TOP = OPT_LEN - 3; // First payload byte in the raw view

  opt_slot_in_t [OPT_NUM_TX-1:0] slot_nxt;
  logic                          rst_int;
  logic                          accept;

  assign rst_int = fsm_rst || done;   // Back to idle after each packet
  assign accept  = req_val && !busy;  // Strobes during a packet are dropped

  // Slot inputs, one option per slot
  always_comb begin
    for (int i = 0; i < OPT_NUM_TX; i++) begin
      slot_nxt[i].payload.raw = {(OPT_LEN-2){DHCP_OPT_PAD}};
    end

    slot_nxt[0].code                = DHCP_OPT_MSG_TYPE;
    slot_nxt[0].len                 = 8'd1;
    slot_nxt[0].payload.raw[PL_TOP] = req.msg_type;

    slot_nxt[1].code                     = DHCP_OPT_REQ_IP;
    slot_nxt[1].len                      = 8'd4;
    slot_nxt[1].payload.raw[PL_TOP -: 4] = req.req_ip;

    // Client id is hardware type then MAC
    slot_nxt[2].code                         = DHCP_OPT_CLI_ID;
    slot_nxt[2].len                          = 8'd7;
    slot_nxt[2].payload.raw[PL_TOP]          = 8'd1;
    slot_nxt[2].payload.raw[PL_TOP-1 -: 6]   = req.cli_id_mac;

    slot_nxt[3].code                                = DHCP_OPT_HOSTNAME;
    slot_nxt[3].len                                 = HOSTNAME_LEN;
    slot_nxt[3].payload.raw[PL_TOP -: HOSTNAME_LEN] = HOSTNAME;

    slot_nxt[4].code                                   = DHCP_OPT_DOMAIN_NAME;
    slot_nxt[4].len                                    = DOMAIN_NAME_LEN;
    slot_nxt[4].payload.raw[PL_TOP -: DOMAIN_NAME_LEN] = DOMAIN_NAME;

    // FQDN goes through the structured view
    slot_nxt[5].code                                     = DHCP_OPT_FQDN;
    slot_nxt[5].len                                      = 8'(FQDN_LEN + 3);
    slot_nxt[5].payload.fqdn.flags                       = req.fqdn_flags;
    slot_nxt[5].payload.fqdn.rcode1                      = req.rcode1;
    slot_nxt[5].payload.fqdn.rcode2                      = req.rcode2;
    slot_nxt[5].payload.fqdn.name[OPT_LEN-6 -: FQDN_LEN] = FQDN;
  end

  always_ff @(posedge clk) begin
    if (rst_int) begin
      busy <= 1'b0;
      load <= 1'b0;
    end else begin
      load <= accept; // One-cycle strobe to the slots
      if (accept) begin
        busy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      slot_in  <= slot_nxt;
      opt_pres <= req.opt_pres;
    end
  end

endmodule

//--- source/dhcp_tx_pkg.sv
package dhcp_tx_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////
  localparam int OPT_LEN        = 16;                       // Bytes per option slot
  localparam int OPT_NUM_TX     = 6;                        // Option slots
  localparam int OPT_TOT_LEN_TX = OPT_NUM_TX * OPT_LEN + 1; // All slots plus END
  localparam int DHCP_HDR_LEN   = 48;                       // Through chaddr, plus cookie
  localparam int UDP_HDR_LEN    = 8;

  // Option codes
  localparam logic [7:0] DHCP_OPT_MSG_TYPE    = 8'd53;
  localparam logic [7:0] DHCP_OPT_REQ_IP      = 8'd50;
  localparam logic [7:0] DHCP_OPT_CLI_ID      = 8'd61;
  localparam logic [7:0] DHCP_OPT_HOSTNAME    = 8'd12;
  localparam logic [7:0] DHCP_OPT_DOMAIN_NAME = 8'd15;
  localparam logic [7:0] DHCP_OPT_FQDN        = 8'd81;
  localparam logic [7:0] DHCP_OPT_PAD         = 8'd0;
  localparam logic [7:0] DHCP_OPT_END         = 8'd255;

  localparam logic [15:0] DHCP_CLI_PORT = 16'd68;
  localparam logic [15:0] DHCP_SRV_PORT = 16'd67;
  localparam logic [47:0] MAC_BROADCAST = 48'hffff_ffff_ffff;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////
  typedef struct packed {
    logic [7:0]       op;
    logic [7:0]       htype;
    logic [7:0]       hlen;
    logic [7:0]       hops;
    logic [31:0]      xid;
    logic [15:0]      secs;
    logic [15:0]      flags;
    logic [31:0]      ciaddr;
    logic [31:0]      yiaddr;
    logic [31:0]      siaddr;
    logic [31:0]      giaddr;
    logic [15:0][7:0] chaddr;
    logic [31:0]      cookie; // Magic cookie
  } dhcp_hdr_t;

  // FQDN option body, 14 bytes
  typedef struct packed {
    logic [7:0]              flags;
    logic [7:0]              rcode1;
    logic [7:0]              rcode2;
    logic [OPT_LEN-6:0][7:0] name;
  } fqdn_t;

  typedef union packed {
    logic [OPT_LEN-3:0][7:0] raw;  // Plain bytes, first byte on top
    fqdn_t                   fqdn;
  } opt_payload_u;

  typedef struct packed {
    logic [7:0]   code;
    logic [7:0]   len;
    opt_payload_u payload;
  } opt_slot_in_t;

  typedef struct packed {
    logic                    present;
    logic [OPT_LEN-1:0][7:0] data;
  } opt_slot_t;

  typedef struct packed {
    dhcp_hdr_t             hdr;
    logic [7:0]            msg_type;
    logic [31:0]           req_ip;
    logic [47:0]           cli_id_mac;
    logic [7:0]            fqdn_flags;
    logic [7:0]            rcode1;
    logic [7:0]            rcode2;
    logic [OPT_NUM_TX-1:0] opt_pres;   // Bit i enables slot i
    logic [31:0]           src_ip;
    logic [31:0]           dst_ip;
    logic [15:0]           ipv4_id;
  } dhcp_req_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] cks;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] ipv4_id;
    logic [47:0] dst_mac;
  } udp_meta_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } udp_strm_t;

endpackage
